// File: mlkem_out.f
+incdir+src
src/mlkem_out_pkg.sv
src/readout_fsm.sv
src/phase_counter.sv
src/phase_table.sv
src/lane_packer.sv
src/word_ram.sv
src/mlkem_out_top.sv
tb/tb_clock.sv
tb/mlkem_out_tb.sv

// File: tb/mlkem_out_tb.sv
`timescale 1ns/100ps

`include "mlkem_out_params.svh"

module mlkem_out_tb import mlkem_out_pkg::*; ();

    // Worst case random mode is gen_keys k4, the abort pair is two encap k2 runs
    localparam int SWEEP_ENTRIES = 2368 + 1104 + 16 + 4672 + 2 * 784;
    localparam int CYCLE_LIMIT   = 2 * SWEEP_ENTRIES + SWEEP_ENTRIES / 4 + 2000;
    localparam int AW            = `RAM_AW;
    localparam logic [3:0] OP_IDLE = 4'h2;  // Neither a read command nor reset

    typedef enum logic [2:0] {st_idle, st_lead, st_sweep, st_tail, st_done} model_e;

    logic               clk;
    logic               rst;
    logic               start;
    mode_ctl_t          control;
    logic [`DIN_W-1:0]  din;
    logic [`RAM_AW-1:0] rd_addr;
    logic [`CNT_W-1:0]  add_ram;
    logic [7:0]         control_core;
    logic [`RAM_W-1:0]  dout;
    logic               end_op;

    // Phase list and packed words expected for the current run
    logic [3:0]         ph_op [8];
    int                 ph_len [8];
    logic               ph_byte [8];
    int                 n_ph = 0;
    logic [`RAM_W-1:0]  exp_buf [`RAM_DEPTH];

    model_e             m_state = st_idle;
    int                 m_idx = 0;
    logic [`CNT_W-1:0]  m_addr = '0;
    logic               m_second = 1'b0;    // Second cycle of an address
    logic [`CNT_W-1:0]  exp_add_ram;
    logic [7:0]         exp_control_core;
    logic               exp_end_op;
    logic               armed = 1'b0;
    logic               rd_on;
    logic               chk_on = 1'b0;
    logic [`RAM_W-1:0]  chk_word;
    int                 value_errs = 0;
    int                 other_errs = 0;
    int                 cycles = 0;
    logic [31:0]        rng = 32'd4403;

    tb_clock u_clock (.clk(clk), .rst(rst));

    mlkem_out_top UUT (
        .clk(clk), .rst(rst), .start(start), .control(control), .din(din),
        .rd_addr(rd_addr), .add_ram(add_ram), .control_core(control_core),
        .dout(dout), .end_op(end_op)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Core data as seen for a command and address, low byte changes every address
    function automatic logic [15:0] din_for(input logic [7:0] code, input logic [15:0] addr);
        logic [15:0] mix;
        mix = addr * 16'h9E37;
        return mix ^ {code, code};
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        value_errs++;
        $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, exp_val, act_val);
    endtask

    task automatic add_phase(input logic [3:0] op, input int len, input logic byte_lanes);
        ph_op[n_ph]   = op;
        ph_len[n_ph]  = len;
        ph_byte[n_ph] = byte_lanes;
        n_ph++;
    endtask

    // Phase list of the mode and the buffer words it should leave behind
    task automatic build_expected(input kem_op_e op_sel, input kem_level_e level,
                                  output int n_words, output int entries);
        int          poly;
        int          ct;
        int          lanes;
        int          lane;
        logic [7:0]  code;
        logic [15:0] word;
        logic [63:0] acc;
        poly = (level == level_k2) ? `LEN_K2_POLY : (level == level_k3) ? `LEN_K3_POLY
                                                                         : `LEN_K4_POLY;
        ct   = (level == level_k2) ? `LEN_K2_POLY : (level == level_k3) ? `LEN_K3_CT
                                                                         : `LEN_K4_CT;
        n_ph = 0;
        case (op_sel)
            kem_gen_keys: begin
                add_phase(op_read_pk, poly, 1'b1);
                add_phase(op_read_ps, `LEN_SEED, 1'b0);
                add_phase(op_read_sk, poly, 1'b1);
                add_phase(op_read_pk, poly, 1'b1);
                add_phase(op_read_ps, `LEN_SEED, 1'b0);
                add_phase(op_read_hek, `LEN_SEED, 1'b0);
                add_phase(op_read_ss, `LEN_SEED, 1'b0);
            end
            kem_encap: begin
                add_phase(op_read_ct, ct, 1'b1);
                add_phase(op_read_ss, `LEN_SEED, 1'b0);
            end
            kem_decap: add_phase(op_read_ss, `LEN_SEED, 1'b0);
            default: ;
        endcase
        if (level == level_none) begin
            n_ph = 0;
        end
        n_words = 0;
        entries = 0;
        acc     = '0;
        for (int p = 0; p < n_ph; p++) begin
            code    = {op_sel, level, ph_op[p]};
            lanes   = ph_byte[p] ? 8 : 4;
            entries = entries + ph_len[p];
            for (int a = 0; a < ph_len[p]; a++) begin
                lane = a % lanes;
                word = din_for(code, 16'(a));
                if (ph_byte[p]) begin
                    acc[lane*8 +: 8] = word[7:0];
                end else begin
                    acc[lane*16 +: 16] = word;
                end
                if (lane == lanes - 1) begin
                    exp_buf[n_words] = acc;
                    n_words++;
                end
            end
        end
    endtask

    // Expected sequencer position, two cycles per address and per step
    always @(posedge clk) begin
        if (!rst || !start || control.op == op_reset) begin
            m_state  <= st_idle;
            m_addr   <= '0;
            m_second <= 1'b0;
        end else begin
            case (m_state)
                st_idle: if (n_ph > 0) m_state <= st_lead;  // Waiting for the first step
                st_lead: begin
                    m_state  <= st_sweep;
                    m_idx    <= 0;
                    m_addr   <= '0;
                    m_second <= 1'b0;
                end
                st_sweep: begin
                    m_second <= !m_second;
                    if (m_second && m_addr == ph_len[m_idx] - 1) begin
                        m_addr <= '0;
                        if (m_idx == n_ph - 1) begin
                            m_state <= st_tail;
                        end else begin
                            m_idx <= m_idx + 1;
                        end
                    end else if (m_second) begin
                        m_addr <= m_addr + 1'b1;
                    end
                end
                st_tail: begin
                    m_second <= !m_second;
                    if (m_second) m_state <= st_done;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        exp_add_ram      = '0;
        exp_control_core = control;
        if (m_state == st_sweep) begin
            exp_add_ram      = m_addr;
            exp_control_core = {control.op_sel, control.level, ph_op[m_idx]};
        end
        exp_end_op = (m_state == st_done);
    end

    always @(posedge clk) begin
        din      <= din_for(control_core, add_ram);
        armed    <= 1'b1;
        chk_on   <= rd_on;                  // dout lags rd_addr by one edge
        chk_word <= exp_buf[rd_addr];
    end

    a_add_ram: assert property (@(posedge clk) armed |-> add_ram == exp_add_ram)
        else report_mismatch("add_ram", $sampled(exp_add_ram), $sampled(add_ram));
    a_control_core: assert property (@(posedge clk) armed |-> control_core == exp_control_core)
        else report_mismatch("control_core", $sampled(exp_control_core), $sampled(control_core));
    a_end_op: assert property (@(posedge clk) armed |-> end_op == exp_end_op)
        else report_mismatch("end_op", $sampled(exp_end_op), $sampled(end_op));
    a_dout: assert property (@(posedge clk) chk_on |-> dout == chk_word)
        else report_mismatch("dout", $sampled(chk_word), $sampled(dout));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: simulation ran past %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic run_mode(input kem_op_e op_sel, input kem_level_e level);
        int n_words;
        int entries;
        int waited;
        build_expected(op_sel, level, n_words, entries);
        @(posedge clk);
        control <= mode_ctl_t'({op_sel, level, OP_IDLE});
        start   <= 1'b1;
        if (n_ph == 0) begin
            repeat (40) @(posedge clk);     // Invalid mode must stay idle
        end else begin
            waited = 0;
            while (!end_op && waited < 2 * entries + 20) begin
                @(posedge clk);
                waited++;
            end
            if (!end_op) begin
                other_errs++;
                $display("end_op did not rise for mode %0h", {op_sel, level});
            end
            repeat (4) @(posedge clk);
            for (int i = 0; i < n_words; i++) begin
                @(posedge clk);
                rd_addr <= AW'(i);
                rd_on   <= 1'b1;
            end
            @(posedge clk);
            rd_on <= 1'b0;
        end
        @(posedge clk);
        start <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    // Reset op in the middle of the ciphertext phase
    task automatic abort_run();
        int n_words;
        int entries;
        int waited;
        build_expected(kem_encap, level_k2, n_words, entries);
        @(posedge clk);
        control <= mode_ctl_t'({kem_encap, level_k2, OP_IDLE});
        start   <= 1'b1;
        waited  = 0;
        while (add_ram != 16'd100 && waited < 1000) begin
            @(posedge clk);
            waited++;
        end
        if (add_ram != 16'd100) begin
            other_errs++;
            $display("Abort test could not reach address 100 before the reset op");
        end
        control <= mode_ctl_t'({kem_encap, level_k2, op_reset});
        repeat (3) @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        control <= mode_ctl_t'({kem_encap, level_k2, OP_IDLE});
        @(posedge clk);
    endtask

    initial begin
        logic [1:0] r_op;
        logic [1:0] r_lvl;
        start   = 1'b0;
        control = mode_ctl_t'({kem_none, level_none, OP_IDLE});
        din     = '0;
        rd_addr = '0;
        rd_on   = 1'b0;
        @(posedge clk);
        while (!rst) @(posedge clk);
        repeat (2) @(posedge clk);
        run_mode(kem_gen_keys, level_k2);
        run_mode(kem_encap, level_k3);
        run_mode(kem_decap, level_k4);
        rng   = xorshift(rng);
        r_op  = 2'(rng % 3) + 2'd1;
        r_lvl = 2'((rng >> 8) % 3) + 2'd1;
        run_mode(kem_op_e'(r_op), kem_level_e'(r_lvl));
        run_mode(kem_none, level_k3);
        run_mode(kem_encap, level_none);
        abort_run();
        run_mode(kem_encap, level_k2);     // Fresh run after the abort
        $display("Summary: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    // Active low reset for the first 8 cycles
    initial begin
        rst = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

// File: src/mlkem_out_top.sv
`timescale 1ns/100ps

`include "mlkem_out_params.svh"

module mlkem_out_top import mlkem_out_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  mode_ctl_t          control,
    input  logic [`DIN_W-1:0]  din,
    input  logic [`RAM_AW-1:0] rd_addr,
    output logic [`CNT_W-1:0]  add_ram,
    output logic [7:0]         control_core,
    output logic [`RAM_W-1:0]  dout,
    output logic               end_op
);

    phase_e             phase;
    phase_cmd_t         cmd;
    logic               step;
    logic               phase_done;
    logic               cap8;
    logic               cap16;
    logic [`RAM_W-1:0]  word8;
    logic [`RAM_W-1:0]  word16;
    logic               done8;
    logic               done16;
    logic               ram_write;
    logic [`RAM_W-1:0]  ram_wdata;

    readout_fsm u_fsm (
        .clk(clk), .rst(rst), .start(start), .control(control),
        .step(step), .phase_done(phase_done), .phase(phase), .end_op(end_op)
    );

    phase_counter u_counter (
        .clk(clk), .rst(rst), .start(start), .control(control), .cmd(cmd),
        .step(step), .count(add_ram), .phase_done(phase_done)
    );

    phase_table u_table (
        .phase(phase), .control(control), .cmd(cmd), .control_core(control_core)
    );

    // Only the packer matching the phase lane width captures
    assign cap8  = step && cmd.valid && cmd.byte_lanes;
    assign cap16 = step && cmd.valid && !cmd.byte_lanes;

    lane_packer #(.lane_t(lane8_t)) u_pack8 (
        .clk(clk), .rst(rst), .capture(cap8), .din(din), .lane_sel(add_ram),
        .word(word8), .word_done(done8)
    );

    lane_packer #(.lane_t(lane16_t)) u_pack16 (
        .clk(clk), .rst(rst), .capture(cap16), .din(din), .lane_sel(add_ram),
        .word(word16), .word_done(done16)
    );

    assign ram_write = done8 || done16;
    assign ram_wdata = done8 ? word8 : word16;

    word_ram u_ram (
        .clk(clk), .rst(rst), .clear(phase == IDLE), .write(ram_write),
        .wdata(ram_wdata), .rd_addr(rd_addr), .rdata(dout)
    );

endmodule

// File: src/word_ram.sv
`timescale 1ns/100ps

`include "mlkem_out_params.svh"

module word_ram (
    input  logic               clk,
    input  logic               rst,
    input  logic               clear,
    input  logic               write,
    input  logic [`RAM_W-1:0]  wdata,
    input  logic [`RAM_AW-1:0] rd_addr,
    output logic [`RAM_W-1:0]  rdata
);

    logic [`RAM_W-1:0]  mem [`RAM_DEPTH];
    logic [`RAM_AW-1:0] wr_ptr;

    // Clear takes priority over a pending write
    always_ff @(posedge clk) begin
        if (!rst || clear) begin
            wr_ptr <= '0;
        end else if (write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        rdata <= mem[rd_addr];  // One cycle read latency
    end

endmodule

// File: src/lane_packer.sv
`timescale 1ns/100ps

`include "mlkem_out_params.svh"

module lane_packer #(
    parameter type lane_t = logic [7:0]
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              capture,
    input  logic [`DIN_W-1:0] din,
    input  logic [`CNT_W-1:0] lane_sel,
    output logic [`RAM_W-1:0] word,
    output logic              word_done
);

    localparam int LANE_W  = $bits(lane_t);
    localparam int N_LANES = `RAM_W / LANE_W;
    localparam int SEL_W   = $clog2(N_LANES);

    lane_t [N_LANES-1:0] lanes;     // Lane 0 is the low end of the word
    logic  [SEL_W-1:0]   idx;
    logic                top_lane;

    assign idx      = lane_sel[SEL_W-1:0];
    assign top_lane = (idx == SEL_W'(N_LANES - 1));

    always_ff @(posedge clk) begin
        if (capture) begin
            lanes[idx] <= din[LANE_W-1:0];  // Byte lanes keep the low byte
        end
    end

    // Word is complete one cycle after its top lane lands
    always_ff @(posedge clk) begin
        if (!rst) begin
            word_done <= 1'b0;
        end else begin
            word_done <= capture && top_lane;
        end
    end

    assign word = lanes;

endmodule

// File: src/phase_table.sv
`timescale 1ns/100ps

`include "mlkem_out_params.svh"

module phase_table import mlkem_out_pkg::*; (
    input  phase_e     phase,
    input  mode_ctl_t  control,
    output phase_cmd_t cmd,
    output logic [7:0] control_core
);

    typedef logic [`CNT_W-1:0] cnt_t;

    cnt_t     poly_len;
    cnt_t     ct_len;
    op_code_e read_op;

    // Level dependent sizes
    always_comb begin
        case (control.level)
            level_k2: begin
                poly_len = cnt_t'(`LEN_K2_POLY);
                ct_len   = cnt_t'(`LEN_K2_POLY);    // Same as the k=2 vector
            end
            level_k3: begin
                poly_len = cnt_t'(`LEN_K3_POLY);
                ct_len   = cnt_t'(`LEN_K3_CT);
            end
            level_k4: begin
                poly_len = cnt_t'(`LEN_K4_POLY);
                ct_len   = cnt_t'(`LEN_K4_CT);
            end
            default: begin
                poly_len = '0;
                ct_len   = '0;
            end
        endcase
    end

    always_comb begin
        cmd.valid      = 1'b1;
        cmd.length     = cnt_t'(`LEN_SEED);
        cmd.byte_lanes = 1'b0;
        read_op        = op_read_ss;
        case (phase)
            LOAD_EK, LOAD_EK_DK: begin
                read_op        = op_read_pk;
                cmd.length     = poly_len;
                cmd.byte_lanes = 1'b1;
            end
            LOAD_DK: begin
                read_op        = op_read_sk;
                cmd.length     = poly_len;
                cmd.byte_lanes = 1'b1;
            end
            LOAD_CT: begin
                read_op        = op_read_ct;
                cmd.length     = ct_len;
                cmd.byte_lanes = 1'b1;
            end
            LOAD_PUBLICSEED, LOAD_PS_DK: read_op = op_read_ps;
            LOAD_HEK:                    read_op = op_read_hek;
            LOAD_Z, LOAD_SS:             read_op = op_read_ss;
            default: begin
                cmd.valid  = 1'b0;      // IDLE, END_READ and DONE
                cmd.length = '0;
            end
        endcase
        cmd.code = {control.op_sel, control.level, read_op};   // Mode kept, op swapped
    end

    assign control_core = cmd.valid ? cmd.code : control;

endmodule

// File: src/phase_counter.sv
`timescale 1ns/100ps

`include "mlkem_out_params.svh"

module phase_counter import mlkem_out_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  mode_ctl_t         control,
    input  phase_cmd_t        cmd,
    output logic              step,
    output logic [`CNT_W-1:0] count,
    output logic              phase_done
);

    logic toggle;       // Half-rate strobe
    logic hold_off;     // Any condition that parks the counters
    logic last;

    assign hold_off = !rst || !start || (control.op == op_reset);

    // First step lands one cycle after start is seen high
    always_ff @(posedge clk) begin
        if (hold_off) begin
            toggle <= 1'b0;
        end else begin
            toggle <= ~toggle;
        end
    end

    assign step = toggle;

    assign last = (count == cmd.length - 1'b1);

    always_ff @(posedge clk) begin
        if (hold_off) begin
            count <= '0;
        end else if (step && cmd.valid) begin
            if (last) begin
                count <= '0;            // Next phase starts at address 0
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    assign phase_done = step && cmd.valid && last;

endmodule

// File: src/readout_fsm.sv
`timescale 1ns/100ps

`include "mlkem_out_params.svh"

module readout_fsm import mlkem_out_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  mode_ctl_t control,
    input  logic      step,
    input  logic      phase_done,
    output phase_e    phase,
    output logic      end_op
);

    phase_e next_phase;
    phase_e first_phase;    // Entry point of the selected operation
    phase_e follow;         // Successor of a load phase
    logic   mode_ok;
    logic   abort;

    assign mode_ok = (control.op_sel != kem_none) && (control.level != level_none);
    assign abort   = (control.op == op_reset);

    always_ff @(posedge clk) begin
        if (!rst || !start || abort) begin
            phase <= IDLE;
        end else begin
            phase <= next_phase;
        end
    end

    always_comb begin
        case (control.op_sel)
            kem_gen_keys: first_phase = LOAD_EK;
            kem_encap:    first_phase = LOAD_CT;
            kem_decap:    first_phase = LOAD_SS;
            default:      first_phase = IDLE;
        endcase
    end

    // Key generation walks the full chain, encap is CT then SS
    always_comb begin
        case (phase)
            LOAD_EK:         follow = LOAD_PUBLICSEED;
            LOAD_PUBLICSEED: follow = LOAD_DK;
            LOAD_DK:         follow = LOAD_EK_DK;
            LOAD_EK_DK:      follow = LOAD_PS_DK;
            LOAD_PS_DK:      follow = LOAD_HEK;
            LOAD_HEK:        follow = LOAD_Z;
            LOAD_Z:          follow = END_READ;
            LOAD_CT:         follow = LOAD_SS;
            LOAD_SS:         follow = END_READ;
            default:         follow = IDLE;
        endcase
    end

    always_comb begin
        next_phase = phase;
        case (phase)
            IDLE: begin
                if (step && mode_ok) begin
                    next_phase = first_phase;
                end
            end
            END_READ: begin
                if (step) begin
                    next_phase = DONE;
                end
            end
            DONE: begin
                next_phase = DONE;      // Left only when start drops
            end
            default: begin
                if (phase_done) begin
                    next_phase = follow;
                end
            end
        endcase
    end

    assign end_op = (phase == DONE);

endmodule

// File: src/mlkem_out_pkg.sv
`include "mlkem_out_params.svh"

package mlkem_out_pkg;

    // Op nibble of the control byte, read commands only plus reset
    typedef enum logic [3:0] {
        op_reset    = 4'h1,
        op_read_sk  = 4'h4,
        op_read_pk  = 4'h6,
        op_read_ct  = 4'h8,
        op_read_ss  = 4'hA,
        op_read_hek = 4'hC,
        op_read_ps  = 4'hE
    } op_code_e;

    typedef enum logic [1:0] {
        kem_none     = 2'd0,
        kem_gen_keys = 2'd1,
        kem_encap    = 2'd2,
        kem_decap    = 2'd3
    } kem_op_e;

    typedef enum logic [1:0] {
        level_none = 2'd0,
        level_k2   = 2'd1,
        level_k3   = 2'd2,
        level_k4   = 2'd3
    } kem_level_e;

    // Control byte as seen on the bus
    typedef struct packed {
        kem_op_e    op_sel;     // Bits 7:6
        kem_level_e level;      // Bits 5:4
        op_code_e   op;         // Bits 3:0
    } mode_ctl_t;

    typedef enum logic [3:0] {
        IDLE,
        LOAD_EK,
        LOAD_PUBLICSEED,
        LOAD_DK,
        LOAD_EK_DK,
        LOAD_PS_DK,
        LOAD_HEK,
        LOAD_Z,
        LOAD_CT,
        LOAD_SS,
        END_READ,
        DONE
    } phase_e;

    typedef struct packed {
        logic               valid;      // Phase reads from the core
        logic [7:0]         code;       // Read command for control_core
        logic [`CNT_W-1:0]  length;     // Entries in this phase
        logic               byte_lanes; // Pack 8 bytes per word
    } phase_cmd_t;

    typedef logic [7:0]  lane8_t;
    typedef logic [15:0] lane16_t;

endpackage

// File: src/mlkem_out_params.svh
`ifndef MLKEM_OUT_PARAMS_SVH
`define MLKEM_OUT_PARAMS_SVH

// Core side widths
`define DIN_W           16      // Data returned by the core
`define CNT_W           16      // Core address and phase length

// Readback buffer
`define RAM_W           64
`define RAM_DEPTH       2048
`define RAM_AW          11

// Phase lengths in core entries
`define LEN_SEED        16      // Seeds, hashes and shared secret

// Polynomial vector per level
`define LEN_K2_POLY     768
`define LEN_K3_POLY     1152
`define LEN_K4_POLY     1536

// Ciphertext, k=2 reuses the poly length
`define LEN_K3_CT       1088
`define LEN_K4_CT       1568

`endif
